// File: Makefile
# Verilator build and run of the MMU testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   list the targets"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module mmu_tb -Mdir obj_dir -o mmu_sim
	./obj_dir/mmu_sim > $(LOG)
	cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/mmu_checker.sv
// reference model of the MMU registers and translation
// compares at the falling edge, model state moves on the rising edge
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_checker
   import mmu_bus_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        soft_reset,
   input  mmu_req_t    req,
   input  logic        fetch_va,
   input  mmu_resp_t   resp,
   input  logic        pxr_wr,
   input  logic        pxr_rd,
   input  logic [1:0]  pxr_be,
   input  logic [7:0]  pxr_addr,
   input  logic [15:0] pxr_wdata,
   input  logic [15:0] pxr_rdata,
   input  logic        exp_rd_en,
   input  logic [15:0] exp_rdata,
   input  logic        exp_acc_en,
   input  mmu_resp_t   exp_resp,
   output int          model_errors,
   output int          table_errors
);

   logic [15:0] m_par [`MMU_ENTRIES];
   logic [15:0] m_pdr [`MMU_ENTRIES];
   logic [15:0] m_mmr0;
   logic [15:0] m_mmr2;
   logic [2:0]  m_mmr3;

   logic [21:0] c_pa;
   logic        c_abort, c_trap, c_nonres, c_ple, c_ro, c_atrap, c_set_a, c_set_w;
   logic [5:0]  c_idx;
   logic [15:0] c_rdata;
   logic [15:0] wmask;

   initial
   begin
      model_errors = 0;
      table_errors = 0;
   end

   task automatic model_access(output logic [21:0] pa, output logic abort,
                               output logic trap, output logic nonres, output logic ple,
                               output logic ro, output logic atrap, output logic set_a,
                               output logic set_w, output logic [5:0] idx);
      logic [1:0]  md;
      logic        split;
      logic [15:0] pdr;
      logic        active;
      logic        tcode;
      logic [6:0]  bn;
      md = req.trap_ctx ? 2'b00 : req.mode;
      split = (md == 2'b00) ? m_mmr3[2] : (md == 2'b01) ? m_mmr3[1] :
              (md == 2'b11) ? m_mmr3[0] : 1'b0;
      idx = {md, split && !req.i_access, req.va[15:13]};
      if (req.va[15:13] == 3'b111)
         pa = `MMU_IOPAGE_BASE | {9'b0, req.va[12:0]};
      else if (m_mmr0[0] && (!m_mmr0[8] || req.d_access))
         pa = {m_par[idx][11:0], 6'b0} + {9'b0, req.va[12:0]};
      else
         pa = {6'b0, req.va};
      pdr = m_pdr[idx];
      active = m_mmr0[0] && (req.rd || req.wr);
      bn = req.va[12:6];
      // only acf bits 2:1 are stored
      nonres = active && (pdr[2:1] == 2'd0);
      ro = active && (pdr[2:1] == 2'd1) && req.wr;
      tcode = (pdr[2:1] == 2'd2);
      set_w = active && (pdr[2:1] == 2'd3) && req.wr;
      ple = active && (pdr[3] ? (bn < pdr[14:8]) : (bn > pdr[14:8]));
      abort = nonres || ro;
      atrap = active && !abort && tcode && m_mmr0[9];
      set_a = active && !abort && tcode;
      trap = active && !abort && (atrap || ple);
   endtask

   always @(posedge clk)
   begin
      model_access(c_pa, c_abort, c_trap, c_nonres, c_ple, c_ro, c_atrap, c_set_a,
                   c_set_w, c_idx);
      if (reset || soft_reset)
      begin
         m_mmr0 = 16'h0000;
         m_mmr2 = 16'h0000;
         m_mmr3 = 3'b000;
      end
      else
      begin
         if (fetch_va && m_mmr0[15:13] == 3'b000)
            m_mmr2 = req.va;
         wmask = {{8{pxr_be[1]}}, {8{pxr_be[0]}}};
         if (pxr_wr && !pxr_addr[7] && pxr_addr[6])
            m_par[pxr_addr[5:0]] = (m_par[pxr_addr[5:0]] & ~wmask) |
                                   (pxr_wdata & `MMU_PAR_MASK & wmask);
         else if (pxr_wr && !pxr_addr[7])
            m_pdr[pxr_addr[5:0]] = (m_pdr[pxr_addr[5:0]] & ~wmask) |
                                   (pxr_wdata & `MMU_PDR_WR_MASK & wmask);
         else if (pxr_wr && pxr_addr[7:6] == 2'b10 && pxr_addr[1:0] == 2'd0)
            m_mmr0 = (m_mmr0 & ~wmask) | (pxr_wdata & wmask);
         else if (pxr_wr && pxr_addr[7:6] == 2'b10 && pxr_addr[1:0] == 2'd3 && pxr_be[0])
            m_mmr3 = pxr_wdata[2:0];
         else if (!pxr_wr)
         begin
            m_mmr0 = m_mmr0 | {c_nonres, c_ple, c_ro, c_atrap, 12'h000};
            if (c_atrap)
               m_mmr0[3:1] = req.va[15:13];
            m_pdr[c_idx] = m_pdr[c_idx] | {8'h00, c_set_a, c_set_w, 6'b000000};
         end
      end
   end

   always @(negedge clk)
   begin
      if (pxr_rd)
      begin
         if (!pxr_addr[7])
            c_rdata = pxr_addr[6] ? m_par[pxr_addr[5:0]] : m_pdr[pxr_addr[5:0]];
         else if (pxr_addr[6])
            c_rdata = 16'h0000;
         else
            case (pxr_addr[1:0])
               2'd0:    c_rdata = m_mmr0;
               2'd2:    c_rdata = m_mmr2;
               2'd3:    c_rdata = {13'b0, m_mmr3};
               default: c_rdata = 16'h0000;
            endcase
         if (pxr_rdata !== c_rdata)
         begin
            $display("ERROR %0t pxr_rdata: got %h, model %h", $time, pxr_rdata, c_rdata);
            model_errors++;
         end
         if (exp_rd_en && pxr_rdata !== exp_rdata)
         begin
            $display("ERROR %0t pxr_rdata: got %h, table %h", $time, pxr_rdata, exp_rdata);
            table_errors++;
         end
      end
      if (req.rd || req.wr)
      begin
         model_access(c_pa, c_abort, c_trap, c_nonres, c_ple, c_ro, c_atrap, c_set_a,
                      c_set_w, c_idx);
         if (resp !== {c_pa, c_abort, c_trap})
         begin
            $display("ERROR %0t resp: got %h, model %h", $time, resp, {c_pa, c_abort, c_trap});
            model_errors++;
         end
         if (exp_acc_en && resp !== exp_resp)
         begin
            $display("ERROR %0t resp: got %h, table %h", $time, resp, exp_resp);
            table_errors++;
         end
      end
   end

endmodule

// File: dv/mmu_tb.sv
// directed table of bus operations and accesses, one step per clock
// page bases are random with a fixed seed
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_tb
   import mmu_bus_pkg::*;
;

   localparam int KIND_WR  = 0;
   localparam int KIND_RD  = 1;
   localparam int KIND_ACC = 2;

   logic clk, reset, soft_reset, fetch_va;
   logic pxr_wr, pxr_rd;
   logic [1:0] pxr_be;
   logic [7:0] pxr_addr;
   logic [15:0] pxr_wdata, pxr_rdata, exp_rdata;
   logic exp_rd_en, exp_acc_en;
   mmu_req_t req;
   mmu_resp_t resp, exp_resp;
   int model_errors, table_errors;

   int kind [80];
   logic [7:0] t_addr [80];
   logic [1:0] t_be [80];
   logic [15:0] t_data [80];
   mmu_req_t t_req [80];
   logic t_fetch [80];
   mmu_resp_t t_resp [80];
   int n_steps;
   int limit;
   int cycles;
   integer seed;
   logic [11:0] p [8];

   mmu_top u_dut (.clk(clk), .reset(reset), .soft_reset(soft_reset), .req(req),
                  .fetch_va(fetch_va), .resp(resp), .pxr_wr(pxr_wr), .pxr_rd(pxr_rd),
                  .pxr_be(pxr_be), .pxr_addr(pxr_addr), .pxr_wdata(pxr_wdata),
                  .pxr_rdata(pxr_rdata));

   mmu_checker u_checker (.clk(clk), .reset(reset), .soft_reset(soft_reset), .req(req),
                          .fetch_va(fetch_va), .resp(resp), .pxr_wr(pxr_wr),
                          .pxr_rd(pxr_rd), .pxr_be(pxr_be), .pxr_addr(pxr_addr),
                          .pxr_wdata(pxr_wdata), .pxr_rdata(pxr_rdata),
                          .exp_rd_en(exp_rd_en), .exp_rdata(exp_rdata),
                          .exp_acc_en(exp_acc_en), .exp_resp(exp_resp),
                          .model_errors(model_errors), .table_errors(table_errors));

   function automatic logic [21:0] mapped_pa(input logic [11:0] base, input logic [15:0] va);
      return {base, 6'b0} + {9'b0, va[12:0]};
   endfunction

   task automatic bus_op(input int k, input logic [7:0] a, input logic [1:0] be,
                         input logic [15:0] d);
      kind[n_steps] = k;
      t_addr[n_steps] = a;
      t_be[n_steps] = be;
      t_data[n_steps] = d;
      t_req[n_steps] = '0;
      t_fetch[n_steps] = 1'b0;
      n_steps++;
   endtask

   task automatic access(input logic [15:0] va, input cpu_mode_e md, input logic wr,
                         input logic i_acc, input logic tc, input logic fetch,
                         input logic [21:0] pa, input logic abort, input logic trap);
      kind[n_steps] = KIND_ACC;
      t_req[n_steps] = '{va: va, mode: md, rd: !wr, wr: wr, i_access: i_acc,
                         d_access: !i_acc, trap_ctx: tc};
      t_fetch[n_steps] = fetch;
      t_resp[n_steps] = '{pa: pa, abort: abort, trap: trap};
      n_steps++;
   endtask

   task automatic build_table;
      // 1: byte lanes and masks
      bus_op(KIND_WR, 8'h40, 2'b11, 16'hFFFF);
      bus_op(KIND_RD, 8'h40, 2'b11, 16'h0FFF);
      bus_op(KIND_WR, 8'h40, 2'b01, 16'h0012);
      bus_op(KIND_RD, 8'h40, 2'b11, 16'h0F12);
      bus_op(KIND_WR, 8'h00, 2'b11, 16'hFFFF);
      bus_op(KIND_RD, 8'h00, 2'b11, 16'h7F0E);
      bus_op(KIND_WR, 8'h80, 2'b01, 16'h0050);
      bus_op(KIND_RD, 8'h80, 2'b11, 16'h0050);
      bus_op(KIND_WR, 8'h80, 2'b10, 16'h1234);
      bus_op(KIND_RD, 8'h80, 2'b11, 16'h1250);
      bus_op(KIND_WR, 8'h80, 2'b11, 16'h0000);
      // 2: unmapped and the I/O page
      access(16'h1234, MODE_KERNEL, 0, 1, 0, 0, 22'h001234, 0, 0);
      access(16'hE010, MODE_USER, 0, 1, 0, 0, 22'h3FE010, 0, 0);
      // 3: kernel I 0, super 1, user 2, kernel D 3, then kernel 4 5 1 2
      bus_op(KIND_WR, 8'h40, 2'b11, {4'h0, p[0]});
      bus_op(KIND_WR, 8'h51, 2'b11, {4'h0, p[1]});
      bus_op(KIND_WR, 8'h72, 2'b11, {4'h0, p[2]});
      bus_op(KIND_WR, 8'h4B, 2'b11, {4'h0, p[3]});
      bus_op(KIND_WR, 8'h44, 2'b11, {4'h0, p[4]});
      bus_op(KIND_WR, 8'h45, 2'b11, {4'h0, p[5]});
      bus_op(KIND_WR, 8'h41, 2'b11, {4'h0, p[6]});
      bus_op(KIND_WR, 8'h42, 2'b11, {4'h0, p[7]});
      bus_op(KIND_WR, 8'h00, 2'b11, 16'h7F06);
      bus_op(KIND_WR, 8'h11, 2'b11, 16'h7F06);
      bus_op(KIND_WR, 8'h32, 2'b11, 16'h7F06);
      bus_op(KIND_WR, 8'h0B, 2'b11, 16'h7F06);
      bus_op(KIND_WR, 8'h04, 2'b11, 16'h7F04);
      bus_op(KIND_WR, 8'h05, 2'b11, 16'h0206);
      bus_op(KIND_WR, 8'h01, 2'b11, 16'h0000);
      bus_op(KIND_WR, 8'h02, 2'b11, 16'h7F02);
      bus_op(KIND_WR, 8'h80, 2'b11, 16'h0001);
      access(16'h0100, MODE_KERNEL, 0, 1, 0, 0, mapped_pa(p[0], 16'h0100), 0, 0);
      access(16'h2040, MODE_SUPER, 0, 1, 0, 0, mapped_pa(p[1], 16'h2040), 0, 0);
      access(16'h4ABC, MODE_USER, 0, 1, 0, 0, mapped_pa(p[2], 16'h4ABC), 0, 0);
      access(16'h0100, MODE_USER, 0, 1, 1, 0, mapped_pa(p[0], 16'h0100), 0, 0);
      bus_op(KIND_WR, 8'h83, 2'b01, 16'h0004);
      access(16'h6010, MODE_KERNEL, 0, 0, 0, 0, mapped_pa(p[3], 16'h6010), 0, 0);
      bus_op(KIND_WR, 8'h83, 2'b01, 16'h0000);
      // 4: non-resident read, read-only write
      access(16'h2000, MODE_KERNEL, 0, 1, 0, 0, mapped_pa(p[6], 16'h2000), 1, 0);
      bus_op(KIND_RD, 8'h80, 2'b11, 16'h8001);
      bus_op(KIND_WR, 8'h80, 2'b11, 16'h0001);
      access(16'h4000, MODE_KERNEL, 1, 1, 0, 0, mapped_pa(p[7], 16'h4000), 1, 0);
      bus_op(KIND_RD, 8'h80, 2'b11, 16'h2001);
      bus_op(KIND_WR, 8'h80, 2'b11, 16'h0001);
      // 5: W on write, A and trap on a trap-coded page
      access(16'h0010, MODE_KERNEL, 1, 1, 0, 0, mapped_pa(p[0], 16'h0010), 0, 0);
      bus_op(KIND_RD, 8'h00, 2'b11, 16'h7F46);
      bus_op(KIND_WR, 8'h80, 2'b11, 16'h0201);
      access(16'h8000, MODE_KERNEL, 0, 1, 0, 0, mapped_pa(p[4], 16'h8000), 0, 1);
      bus_op(KIND_RD, 8'h80, 2'b11, 16'h1209);
      bus_op(KIND_RD, 8'h04, 2'b11, 16'h7F84);
      bus_op(KIND_WR, 8'h80, 2'b11, 16'h0001);
      // 6: length error, then MMR2 tracking and freezing
      access(16'hA0C0, MODE_KERNEL, 0, 1, 0, 0, mapped_pa(p[5], 16'hA0C0), 0, 1);
      bus_op(KIND_RD, 8'h80, 2'b11, 16'h4001);
      bus_op(KIND_WR, 8'h80, 2'b11, 16'h0001);
      access(16'h0020, MODE_KERNEL, 0, 1, 0, 1, mapped_pa(p[0], 16'h0020), 0, 0);
      bus_op(KIND_RD, 8'h82, 2'b11, 16'h0020);
      access(16'h2004, MODE_KERNEL, 0, 1, 0, 1, mapped_pa(p[6], 16'h2004), 1, 0);
      access(16'h0030, MODE_KERNEL, 0, 1, 0, 1, mapped_pa(p[0], 16'h0030), 0, 0);
      bus_op(KIND_RD, 8'h82, 2'b11, 16'h2004);
      bus_op(KIND_WR, 8'h80, 2'b11, 16'h0000);
   endtask

   task automatic drive_idle;
      pxr_wr <= 1'b0;
      pxr_rd <= 1'b0;
      req <= '0;
      fetch_va <= 1'b0;
      exp_rd_en <= 1'b0;
      exp_acc_en <= 1'b0;
   endtask

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      soft_reset = 1'b0;
      pxr_wr = 1'b0;
      pxr_rd = 1'b0;
      pxr_be = 2'b00;
      pxr_addr = 8'h00;
      pxr_wdata = 16'h0000;
      req = '0;
      fetch_va = 1'b0;
      exp_rd_en = 1'b0;
      exp_rdata = 16'h0000;
      exp_acc_en = 1'b0;
      exp_resp = '0;
      cycles = 0;
      seed = 6;
      n_steps = 0;
      for (int i = 0; i < 8; i++)
         p[i] = $random(seed);
      build_table();
      limit = n_steps * 4 + 50;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      for (int s = 0; s < n_steps; s++)
      begin
         @(posedge clk);
         pxr_wr <= (kind[s] == KIND_WR);
         pxr_rd <= (kind[s] == KIND_RD);
         pxr_be <= t_be[s];
         pxr_addr <= t_addr[s];
         pxr_wdata <= t_data[s];
         exp_rd_en <= (kind[s] == KIND_RD);
         exp_rdata <= t_data[s];
         req <= t_req[s];
         fetch_va <= t_fetch[s];
         exp_acc_en <= (kind[s] == KIND_ACC);
         exp_resp <= t_resp[s];
      end
      @(posedge clk);
      drive_idle();
      @(posedge clk);
      $display("errors: %0d against model, %0d against table", model_errors, table_errors);
      if (model_errors == 0 && table_errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   // run limit from the table length
   always @(posedge clk)
   begin
      cycles++;
      if (limit > 0 && cycles > limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", limit);
         $display("Done: errors found");
         $finish;
      end
   end

endmodule

// File: sources.f
+incdir+src
src/mmu_bus_pkg.sv
src/mmu_reg_pkg.sv
src/mmu_page_table.sv
src/mmu_status_regs.sv
src/mmu_addr_map.sv
src/mmu_access_check.sv
src/mmu_top.sv
dv/mmu_checker.sv
dv/mmu_tb.sv

// File: src/mmu_access_check.sv
// access-control and page-length checks in the same cycle as the access
// checks are only active with mapping on; abort masks trap
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_access_check
   import mmu_bus_pkg::*, mmu_reg_pkg::*;
(
   input  mmu_req_t              req,
   input  logic                  mmu_on,
   input  logic                  traps_en,
   input  pdr_t                  pdr,
   input  logic [`MMU_IDX_W-1:0] index,
   output fault_t                fault,
   output pdr_upd_t              upd,
   output logic                  abort,
   output logic                  trap
);

   logic [6:0] bn;
   logic       len_err;
   logic       active;
   logic       deny_nonres;
   logic       deny_ro;
   logic       deny;
   logic       trap_code;
   logic       set_w;
   logic       acf_trap;

   // block number within the page
   assign bn      = req.va[12:6];
   // ed set means the page grows downward
   assign len_err = pdr.ed ? (bn < pdr.plf) : (bn > pdr.plf);
   assign active  = mmu_on && (req.rd || req.wr);

   always_comb
   begin
      deny_nonres = 1'b0;
      deny_ro     = 1'b0;
      trap_code   = 1'b0;
      set_w       = 1'b0;
      case (pdr.acf)
         ACF_RO_TRAP:
         begin
            deny_ro   = req.wr;
            trap_code = !req.wr;
         end
         ACF_RO:
            deny_ro = req.wr;
         ACF_RW_TRAP_ANY:
            trap_code = 1'b1;
         ACF_RW_TRAP_WR:
            trap_code = req.wr;
         ACF_RW:
            set_w = req.wr;
         // non-resident and the unused codes
         default:
            deny_nonres = 1'b1;
      endcase
   end

   assign deny     = deny_nonres || deny_ro;
   assign acf_trap = active && !deny && trap_code && traps_en;

   assign abort = active && deny;
   assign trap  = active && !deny && (acf_trap || len_err);

   // length error recorded even when the access aborts
   assign fault = '{nonres:      active && deny_nonres,
                    ple:         active && len_err,
                    ro:          active && deny_ro,
                    trap_flag:   acf_trap,
                    record_page: acf_trap,
                    apf:         req.va[15:13]};

   assign upd = '{set_a: active && !deny && trap_code,
                  set_w: active && set_w,
                  index: index};

endmodule

// File: src/mmu_addr_map.sv
// virtual to physical translation, purely combinational
// page 7 always goes to the I/O page, mapped or not
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_addr_map
   import mmu_bus_pkg::*;
(
   input  mmu_req_t              req,
   input  logic                  mmu_on,
   input  logic                  maint_mode,
   input  logic [2:0]            split_id,
   input  logic [11:0]           par,
   output logic [`MMU_IDX_W-1:0] index,
   output logic [`MMU_PA_W-1:0]  pa
);

   cpu_mode_e            eff_mode;
   logic [2:0]           apf;
   logic [12:0]          disp;
   logic                 split_en;
   logic                 d_space;
   logic                 map_en;
   logic [`MMU_PA_W-1:0] pa_mapped;

   assign apf  = req.va[15:13];
   assign disp = req.va[12:0];

   // trap context runs in kernel space
   assign eff_mode = req.trap_ctx ? MODE_KERNEL : req.mode;

   // split_id: 2 kernel, 1 super, 0 user
   always_comb
   begin
      case (eff_mode)
         MODE_KERNEL: split_en = split_id[2];
         MODE_SUPER:  split_en = split_id[1];
         MODE_USER:   split_en = split_id[0];
         default:     split_en = 1'b0;
      endcase
   end

   assign d_space = split_en && !req.i_access;
   assign index   = {eff_mode, d_space, apf};

   // maintenance mode maps destination accesses only
   assign map_en = mmu_on && (!maint_mode || req.d_access);

   assign pa_mapped = map_en ? ({4'b0, par, 6'b0} + {9'b0, disp}) : {6'b0, req.va};

   assign pa = (apf == 3'b111) ? (`MMU_IOPAGE_BASE | {9'b0, disp}) : pa_mapped;

endmodule

// File: src/mmu_bus_pkg.sv
// processor side of the MMU: one access per cycle, answered in the same cycle
// mode 2'b10 is not a legal processor mode
`include "mmu_params.svh"

package mmu_bus_pkg;

   typedef enum logic [1:0] {
      MODE_KERNEL = 2'b00,
      MODE_SUPER  = 2'b01,
      MODE_USER   = 2'b11
   } cpu_mode_e;

   // access presented by the processor
   typedef struct packed {
      logic [`MMU_VA_W-1:0] va;
      cpu_mode_e            mode;
      logic                 rd;
      logic                 wr;
      logic                 i_access;
      logic                 d_access;
      // trap or interrupt vector fetch, always mapped through kernel space
      logic                 trap_ctx;
   } mmu_req_t;

   // translation result
   typedef struct packed {
      logic [`MMU_PA_W-1:0] pa;
      logic                 abort;
      logic                 trap;
   } mmu_resp_t;

endpackage

// File: src/mmu_page_table.sv
// PAR/PDR storage, 64 entries each, byte writable over the register bus
// contents are not reset, software loads them before mapping is enabled
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_page_table
   import mmu_reg_pkg::*;
(
   input  logic                  clk,
   input  logic                  pxr_wr,
   input  logic                  pxr_rd,
   input  logic [1:0]            pxr_be,
   input  logic [7:0]            pxr_addr,
   input  logic [15:0]           pxr_wdata,
   input  logic [`MMU_IDX_W-1:0] index,
   input  pdr_upd_t              upd,
   output logic [11:0]           par,
   output pdr_t                  pdr,
   output logic [15:0]           rdata
);

   logic [7:0] par_h [`MMU_ENTRIES];
   logic [7:0] par_l [`MMU_ENTRIES];
   logic [7:0] pdr_h [`MMU_ENTRIES];
   logic [7:0] pdr_l [`MMU_ENTRIES];

   logic [`MMU_IDX_W-1:0] bus_idx;
   logic                  tbl_wr;
   logic [15:0]           wr_par;
   logic [15:0]           wr_pdr;
   logic [15:0]           par_word;
   logic [15:0]           pdr_word;
   logic [15:0]           bus_word;

   // pxr_addr: 7 status, 6 par/pdr, 5:0 entry
   assign bus_idx = pxr_addr[5:0];
   assign tbl_wr  = pxr_wr && !pxr_addr[7];
   assign wr_par  = pxr_wdata & `MMU_PAR_MASK;
   assign wr_pdr  = pxr_wdata & `MMU_PDR_WR_MASK;

   // translation lookup
   assign par_word = {par_h[index], par_l[index]} & `MMU_PAR_MASK;
   assign pdr_word = {pdr_h[index], pdr_l[index]} & `MMU_PDR_MASK;
   assign par      = par_word[11:0];
   assign pdr      = '{plf: pdr_word[14:8],
                       w:   pdr_word[6],
                       ed:  pdr_word[3],
                       acf: acf_e'(pdr_word[2:0])};

   // bus read, the status block merges this into pxr_rdata
   always_comb
   begin
      if (pxr_addr[6])
         bus_word = {par_h[bus_idx], par_l[bus_idx]} & `MMU_PAR_MASK;
      else
         bus_word = {pdr_h[bus_idx], pdr_l[bus_idx]} & `MMU_PDR_MASK;
   end

   assign rdata = (pxr_rd && !pxr_addr[7]) ? bus_word : 16'h0000;

   always_ff @(posedge clk)
   begin
      if (pxr_wr)
      begin
         if (tbl_wr && pxr_addr[6])
         begin
            if (pxr_be[1])
               par_h[bus_idx] <= wr_par[15:8];
            if (pxr_be[0])
               par_l[bus_idx] <= wr_par[7:0];
         end
         else if (tbl_wr)
         begin
            if (pxr_be[1])
               pdr_h[bus_idx] <= wr_pdr[15:8];
            if (pxr_be[0])
               pdr_l[bus_idx] <= wr_pdr[7:0];
         end
      end
      // a in bit 7, w in bit 6, both in the low byte
      else if (upd.set_a || upd.set_w)
      begin
         pdr_l[upd.index] <= pdr_l[upd.index] | {upd.set_a, upd.set_w, 6'b000000};
      end
   end

   // one access never sets a and w together
   a_upd_single: assert property (@(posedge clk) !(upd.set_a && upd.set_w));

endmodule

// File: src/mmu_params.svh
// masks follow the 11/34a layout, so acf bit 0 and pdr bits 5:4 are never stored
// a and w in the pdr are set by hardware and cannot be written over the bus
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// readable pdr bits: plf 14:8, a 7, w 6, ed 3, acf 2:1
`define MMU_PDR_MASK     16'o077716
// bus-writable pdr bits
`define MMU_PDR_WR_MASK  16'o077416
// 12-bit page base
`define MMU_PAR_MASK     16'o007777

// 3 modes x i/d x 8 pages, index is {mode, d, apf}
`define MMU_ENTRIES      64
`define MMU_IDX_W        6

`define MMU_VA_W         16
`define MMU_PA_W         22

// top 8 KB of the 22-bit space
`define MMU_IOPAGE_BASE  22'o17760000

`endif

// File: src/mmu_reg_pkg.sv
// register layouts of the KT-11 style MMU
// unused access-control codes behave as non-resident
`include "mmu_params.svh"

package mmu_reg_pkg;

   typedef enum logic [2:0] {
      ACF_NONRES      = 3'd0,
      ACF_RO_TRAP     = 3'd1,
      ACF_RO          = 3'd2,
      ACF_UNUSED      = 3'd3,
      ACF_RW_TRAP_ANY = 3'd4,
      ACF_RW_TRAP_WR  = 3'd5,
      ACF_RW          = 3'd6
   } acf_e;

   // pdr fields seen by the access checker
   typedef struct packed {
      logic [6:0] plf;
      logic       w;
      logic       ed;
      acf_e       acf;
   } pdr_t;

   typedef struct packed {
      logic       abort_nonres;
      logic       abort_ple;
      logic       abort_ro;
      logic       trap_flag;
      logic [1:0] rsvd_11_10;
      logic       traps_en;
      logic       maint;
      logic [3:0] rsvd_7_4;
      logic [2:0] page;
      logic       enable;
   } mmr0_t;

   // status register select, pxr_addr 1:0
   typedef enum logic [1:0] {
      SEL_MMR0 = 2'd0,
      SEL_MMR1 = 2'd1,
      SEL_MMR2 = 2'd2,
      SEL_MMR3 = 2'd3
   } mmr_sel_e;

   // one access worth of mmr0 update strobes
   typedef struct packed {
      logic       nonres;
      logic       ple;
      logic       ro;
      logic       trap_flag;
      logic       record_page;
      logic [2:0] apf;
   } fault_t;

   typedef struct packed {
      logic                  set_a;
      logic                  set_w;
      logic [`MMU_IDX_W-1:0] index;
   } pdr_upd_t;

endpackage

// File: src/mmu_status_regs.sv
// MMR0, MMR2 and MMR3 plus the register bus read mux
// MMR1 reads as zero, MMR3 keeps only the split I/D enables in bits 2:0
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_status_regs
   import mmu_reg_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 soft_reset,
   input  logic                 pxr_wr,
   input  logic                 pxr_rd,
   input  logic [1:0]           pxr_be,
   input  logic [7:0]           pxr_addr,
   input  logic [15:0]          pxr_wdata,
   input  fault_t               fault,
   input  logic                 fetch_va,
   input  logic [`MMU_VA_W-1:0] va,
   input  logic [15:0]          table_rdata,
   output logic                 mmu_on,
   output logic                 maint_mode,
   output logic                 traps_en,
   output logic [2:0]           split_id,
   output logic [15:0]          rdata
);

   mmr0_t                mmr0;
   logic [`MMU_VA_W-1:0] mmr2;
   logic [2:0]           mmr3;
   mmr_sel_e             sel;
   logic                 mmr_wr;
   logic                 aborted;

   assign sel     = mmr_sel_e'(pxr_addr[1:0]);
   assign mmr_wr  = pxr_wr && (pxr_addr[7:6] == 2'b10);
   assign aborted = mmr0.abort_nonres || mmr0.abort_ple || mmr0.abort_ro;

   always_ff @(posedge clk)
   begin
      if (reset || soft_reset)
      begin
         mmr0 <= '0;
         mmr3 <= 3'b000;
      end
      else if (pxr_wr)
      begin
         if (mmr_wr && sel == SEL_MMR0)
         begin
            if (pxr_be[1])
               mmr0[15:8] <= pxr_wdata[15:8];
            if (pxr_be[0])
               mmr0[7:0] <= pxr_wdata[7:0];
         end
         if (mmr_wr && sel == SEL_MMR3 && pxr_be[0])
            mmr3 <= pxr_wdata[2:0];
      end
      else
      begin
         // sticky until software clears them
         mmr0.abort_nonres <= mmr0.abort_nonres | fault.nonres;
         mmr0.abort_ple    <= mmr0.abort_ple | fault.ple;
         mmr0.abort_ro     <= mmr0.abort_ro | fault.ro;
         mmr0.trap_flag    <= mmr0.trap_flag | fault.trap_flag;
         if (fault.record_page)
            mmr0.page <= fault.apf;
      end
   end

   // frozen once an abort is recorded
   always_ff @(posedge clk)
   begin
      if (reset || soft_reset)
         mmr2 <= '0;
      else if (fetch_va && !aborted)
         mmr2 <= va;
   end

   assign mmu_on     = mmr0.enable;
   assign maint_mode = mmr0.maint;
   assign traps_en   = mmr0.traps_en;
   assign split_id   = mmr3;

   always_comb
   begin
      rdata = 16'h0000;
      if (pxr_rd && !pxr_addr[7])
         rdata = table_rdata;
      else if (pxr_rd && !pxr_addr[6])
      begin
         case (sel)
            SEL_MMR0: rdata = mmr0;
            SEL_MMR2: rdata = mmr2;
            SEL_MMR3: rdata = {13'b0, mmr3};
            default:  rdata = 16'h0000;
         endcase
      end
   end

   // access faults only arrive while mapping is on
   a_fault_quiet: assert property (@(posedge clk) disable iff (reset || soft_reset)
      (!mmu_on && !pxr_wr) |=> $stable(mmr0[15:12]));

endmodule

// File: src/mmu_top.sv
// KT-11 style MMU: translation and checks are combinational,
// register writes and W/A/fault updates land on the next clk
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_top
   import mmu_bus_pkg::*, mmu_reg_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        soft_reset,
   input  mmu_req_t    req,
   input  logic        fetch_va,
   output mmu_resp_t   resp,
   input  logic        pxr_wr,
   input  logic        pxr_rd,
   input  logic [1:0]  pxr_be,
   input  logic [7:0]  pxr_addr,
   input  logic [15:0] pxr_wdata,
   output logic [15:0] pxr_rdata
);

   logic                  mmu_on;
   logic                  maint_mode;
   logic                  traps_en;
   logic [2:0]            split_id;
   logic [`MMU_IDX_W-1:0] index;
   logic [11:0]           par;
   pdr_t                  pdr;
   fault_t                fault;
   pdr_upd_t              upd;
   logic [15:0]           table_rdata;
   logic [`MMU_PA_W-1:0]  pa;
   logic                  abort;
   logic                  trap;

   assign resp = '{pa: pa, abort: abort, trap: trap};

   mmu_page_table u_page_table (
      .clk       (clk),
      .pxr_wr    (pxr_wr),
      .pxr_rd    (pxr_rd),
      .pxr_be    (pxr_be),
      .pxr_addr  (pxr_addr),
      .pxr_wdata (pxr_wdata),
      .index     (index),
      .upd       (upd),
      .par       (par),
      .pdr       (pdr),
      .rdata     (table_rdata)
   );

   mmu_status_regs u_status_regs (
      .clk         (clk),
      .reset       (reset),
      .soft_reset  (soft_reset),
      .pxr_wr      (pxr_wr),
      .pxr_rd      (pxr_rd),
      .pxr_be      (pxr_be),
      .pxr_addr    (pxr_addr),
      .pxr_wdata   (pxr_wdata),
      .fault       (fault),
      .fetch_va    (fetch_va),
      .va          (req.va),
      .table_rdata (table_rdata),
      .mmu_on      (mmu_on),
      .maint_mode  (maint_mode),
      .traps_en    (traps_en),
      .split_id    (split_id),
      .rdata       (pxr_rdata)
   );

   mmu_addr_map u_addr_map (
      .req        (req),
      .mmu_on     (mmu_on),
      .maint_mode (maint_mode),
      .split_id   (split_id),
      .par        (par),
      .index      (index),
      .pa         (pa)
   );

   mmu_access_check u_access_check (
      .req      (req),
      .mmu_on   (mmu_on),
      .traps_en (traps_en),
      .pdr      (pdr),
      .index    (index),
      .fault    (fault),
      .upd      (upd),
      .abort    (abort),
      .trap     (trap)
   );

endmodule
